/* design/rs_params.svh */
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

//////////////////////////////////////////////////
// station sizing
//////////////////////////////////////////////////

`define RS_SIZE      8   // number of entries
`define PRF_SIZE     64  // physical registers, tag is log2 of this
`define ROB_SIZE     16  // rob index carries one extra bit for the thread
`define DATA_WIDTH   64

//////////////////////////////////////////////////
// functional unit ports
//////////////////////////////////////////////////

`define NUM_FU       6   // mult 0/1, adder 2/3, memory 4/5
`define FU_PER_CLASS 2

`endif

/* design/rs_pkg.sv */
`include "rs_params.svh"

package rs_pkg;

	typedef logic [`DATA_WIDTH-1:0]         word_t;
	typedef logic [$clog2(`PRF_SIZE)-1:0]   tag_t;
	typedef logic [$clog2(`ROB_SIZE):0]     rob_idx_t;  // msb set means thread 2
	typedef logic [$clog2(`RS_SIZE)-1:0]    rs_idx_t;

	typedef enum logic [1:0] {
		FU_MULT   = 2'd0,
		FU_ADDER  = 2'd1,
		FU_MEMORY = 2'd2
	} fu_class_t;

	typedef enum logic [4:0] {
		ALU_DEFAULT = 5'h00,
		ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT, ALU_XOR,
		ALU_EQV, ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ,
		ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT, ALU_CMPULE
	} alu_func_t;

	// when valid is low the low bits of value hold the producer tag
	typedef struct packed {
		word_t value;
		logic  valid;
	} operand_t;

	typedef struct packed {
		logic      load;
		tag_t      dest;
		operand_t  opa;
		operand_t  opb;
		rob_idx_t  rob_idx;
		alu_func_t alu_func;
		fu_class_t fu_class;
	} dispatch_t;

	typedef struct packed {
		word_t value;
		tag_t  tag;
		logic  valid;
	} cdb_t;

	typedef struct packed {
		word_t     opa;
		word_t     opb;
		tag_t      dest;
		rob_idx_t  rob_idx;
		alu_func_t alu_func;
	} issue_t;

	// tag match against both result buses, cdb1 has priority
	function automatic operand_t cdb_capture(operand_t op, cdb_t c1, cdb_t c2);
		operand_t res;
		res = op;
		if (!op.valid) begin
			if (c1.valid && c1.tag == op.value[$bits(tag_t)-1:0]) begin
				res.value = c1.value;
				res.valid = 1'b1;
			end else if (c2.valid && c2.tag == op.value[$bits(tag_t)-1:0]) begin
				res.value = c2.value;
				res.valid = 1'b1;
			end
		end
		return res;
	endfunction

endpackage

/* design/rs_operand_bypass.sv */
`timescale 1ns/1ps

module rs_operand_bypass (
	input  rs_pkg::dispatch_t inst1,  // from rename
	input  rs_pkg::dispatch_t inst2,
	input  rs_pkg::cdb_t      cdb1,
	input  rs_pkg::cdb_t      cdb2,
	output rs_pkg::dispatch_t fwd1,   // operands patched with same-cycle results
	output rs_pkg::dispatch_t fwd2
);
	import rs_pkg::*;

	//////////////////////////////////////////////////
	// same-cycle forwarding
	//////////////////////////////////////////////////

	// a producer broadcasting in the dispatch cycle would otherwise be missed,
	// since the entry only starts snooping after it is written
	always_comb begin
		fwd1     = inst1;
		fwd1.opa = cdb_capture(inst1.opa, cdb1, cdb2);
		fwd1.opb = cdb_capture(inst1.opb, cdb1, cdb2);
	end

	always_comb begin
		fwd2     = inst2;
		fwd2.opa = cdb_capture(inst2.opa, cdb1, cdb2);
		fwd2.opb = cdb_capture(inst2.opb, cdb1, cdb2);
	end

endmodule

/* design/rs_entry_array.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_entry_array (
	input                                       clk,
	input                                       rst,
	input  rs_pkg::dispatch_t                   fwd1,
	input  rs_pkg::dispatch_t                   fwd2,
	input  [`RS_SIZE-1:0]                       alloc1,       // one-hot inst1 target
	input  [`RS_SIZE-1:0]                       alloc2,       // one-hot inst2 target
	input  rs_pkg::cdb_t                        cdb1,
	input  rs_pkg::cdb_t                        cdb2,
	input  [`RS_SIZE-1:0]                       issue_clear,
	input  [`RS_SIZE-1:0]                       flush_clear,
	output logic [`RS_SIZE-1:0]                 busy,
	output logic [`RS_SIZE-1:0]                 ready,
	output rs_pkg::fu_class_t [`RS_SIZE-1:0]    ent_class,
	output rs_pkg::rob_idx_t [`RS_SIZE-1:0]     ent_rob_idx,
	output rs_pkg::issue_t [`RS_SIZE-1:0]       ent_payload
);
	import rs_pkg::*;

	operand_t  [`RS_SIZE-1:0] ent_opa;
	operand_t  [`RS_SIZE-1:0] ent_opb;
	tag_t      [`RS_SIZE-1:0] ent_dest;
	alu_func_t [`RS_SIZE-1:0] ent_alu_func;

	//////////////////////////////////////////////////
	// occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst)
			busy <= '0;
		else
			busy <= (busy & ~(issue_clear | flush_clear)) | alloc1 | alloc2;
	end

	//////////////////////////////////////////////////
	// entry contents and wakeup
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (alloc1[i]) begin
				ent_opa[i]      <= fwd1.opa;
				ent_opb[i]      <= fwd1.opb;
				ent_dest[i]     <= fwd1.dest;
				ent_rob_idx[i]  <= fwd1.rob_idx;
				ent_alu_func[i] <= fwd1.alu_func;
				ent_class[i]    <= fwd1.fu_class;
			end else if (alloc2[i]) begin
				ent_opa[i]      <= fwd2.opa;
				ent_opb[i]      <= fwd2.opb;
				ent_dest[i]     <= fwd2.dest;
				ent_rob_idx[i]  <= fwd2.rob_idx;
				ent_alu_func[i] <= fwd2.alu_func;
				ent_class[i]    <= fwd2.fu_class;
			end else begin
				ent_opa[i] <= cdb_capture(ent_opa[i], cdb1, cdb2);  // snoop while waiting
				ent_opb[i] <= cdb_capture(ent_opb[i], cdb1, cdb2);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			ready[i]                = busy[i] && ent_opa[i].valid && ent_opb[i].valid;
			ent_payload[i].opa      = ent_opa[i].value;
			ent_payload[i].opb      = ent_opb[i].value;
			ent_payload[i].dest     = ent_dest[i];
			ent_payload[i].rob_idx  = ent_rob_idx[i];
			ent_payload[i].alu_func = ent_alu_func[i];
		end
	end

	// the allocator must pick two distinct idle entries
	a_alloc_free: assert property (@(posedge clk) disable iff (rst)
		((alloc1 & alloc2) == '0) && (((alloc1 | alloc2) & busy) == '0));

endmodule

/* design/rs_control.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_control (
	input                                       clk,
	input                                       rst,
	input                                       inst1_load,
	input                                       inst2_load,
	input  [`RS_SIZE-1:0]                       busy,
	input  [`RS_SIZE-1:0]                       ready,
	input  rs_pkg::fu_class_t [`RS_SIZE-1:0]    ent_class,
	input  rs_pkg::rob_idx_t [`RS_SIZE-1:0]     ent_rob_idx,
	input  [`NUM_FU-1:0]                        fu_available,
	input                                       branch_taken_t1,
	input                                       branch_taken_t2,
	output logic [`RS_SIZE-1:0]                 alloc1,
	output logic [`RS_SIZE-1:0]                 alloc2,
	output logic [`RS_SIZE-1:0]                 issue_clear,
	output rs_pkg::rs_idx_t [`NUM_FU-1:0]       issue_sel,
	output logic [`NUM_FU-1:0]                  fu_valid,
	output logic [`RS_SIZE-1:0]                 flush_clear,
	output logic                                rs_full
);
	import rs_pkg::*;

	logic [`RS_SIZE-1:0]              free_first;
	logic [`RS_SIZE-1:0]              free_second;
	logic [`NUM_FU-1:0][`RS_SIZE-1:0] port_pick;  // one-hot entry per port

	// isolate lowest set bit
	function automatic logic [`RS_SIZE-1:0] lowest_one(input logic [`RS_SIZE-1:0] v);
		return v & (~v + 1'b1);
	endfunction

	function automatic rs_idx_t onehot_to_idx(input logic [`RS_SIZE-1:0] v);
		rs_idx_t idx;
		idx = '0;
		for (int i = 0; i < `RS_SIZE; i++)
			if (v[i])
				idx = rs_idx_t'(i);
		return idx;
	endfunction

	//////////////////////////////////////////////////
	// allocation
	//////////////////////////////////////////////////

	assign free_first  = lowest_one(~busy);
	assign free_second = lowest_one(~busy & ~free_first);

	// inst2 never loads alone, and needs a second free slot
	assign alloc1  = inst1_load ? free_first : '0;
	assign alloc2  = (inst1_load && inst2_load) ? free_second : '0;
	assign rs_full = &busy;

	//////////////////////////////////////////////////
	// issue select over two ports per class
	//////////////////////////////////////////////////

	always_comb begin
		logic [`RS_SIZE-1:0] cand;
		logic [`RS_SIZE-1:0] first;
		logic [`RS_SIZE-1:0] second;
		int                  lo;
		port_pick = '0;
		for (int c = 0; c < `NUM_FU / `FU_PER_CLASS; c++) begin
			lo = c * `FU_PER_CLASS;
			for (int i = 0; i < `RS_SIZE; i++)
				cand[i] = ready[i] && (ent_class[i] == fu_class_t'(c));
			first  = lowest_one(cand);
			second = lowest_one(cand & ~first);
			if (fu_available[lo]) begin
				port_pick[lo] = first;
				if (fu_available[lo+1])
					port_pick[lo+1] = second;
			end else if (fu_available[lo+1]) begin
				port_pick[lo+1] = first;  // oldest slot goes high while the lower port is busy
			end
		end
	end

	always_comb begin
		issue_clear = '0;
		for (int p = 0; p < `NUM_FU; p++) begin
			fu_valid[p]  = |port_pick[p];
			issue_sel[p] = onehot_to_idx(port_pick[p]);
			issue_clear  = issue_clear | port_pick[p];
		end
	end

	//////////////////////////////////////////////////
	// thread flush
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++)
			flush_clear[i] = busy[i] && (ent_rob_idx[i][$clog2(`ROB_SIZE)] ?
				branch_taken_t2 : branch_taken_t1);
	end

	// a shared entry would leave fewer clear bits than valid ports
	a_one_port_per_entry: assert property (@(posedge clk) disable iff (rst)
		$countones(issue_clear) == $countones(fu_valid));

endmodule

/* design/rs_issue_mux.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_issue_mux (
	input  rs_pkg::issue_t [`RS_SIZE-1:0]       ent_payload,
	input  rs_pkg::rs_idx_t [`NUM_FU-1:0]       issue_sel,
	input  [`NUM_FU-1:0]                        fu_valid,
	output rs_pkg::issue_t [`NUM_FU-1:0]        fu_issue
);
	import rs_pkg::*;

	always_comb begin
		for (int p = 0; p < `NUM_FU; p++) begin
			fu_issue[p]          = '0;           // idle port drives zeros
			fu_issue[p].alu_func = ALU_DEFAULT;
			if (fu_valid[p])
				fu_issue[p] = ent_payload[issue_sel[p]];
		end
	end

endmodule

/* design/rs_top.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_top (
	input                                       clk,
	input                                       rst,
	input  rs_pkg::dispatch_t                   inst1,
	input  rs_pkg::dispatch_t                   inst2,
	input  rs_pkg::cdb_t                        cdb1,
	input  rs_pkg::cdb_t                        cdb2,
	input  [`NUM_FU-1:0]                        fu_available,  // mult 0/1, adder 2/3, mem 4/5
	input                                       branch_taken_t1,
	input                                       branch_taken_t2,
	output rs_pkg::issue_t [`NUM_FU-1:0]        fu_issue,
	output logic [`NUM_FU-1:0]                  fu_valid,
	output logic                                rs_full
);
	import rs_pkg::*;

	dispatch_t                fwd1;
	dispatch_t                fwd2;
	logic [`RS_SIZE-1:0]      alloc1;
	logic [`RS_SIZE-1:0]      alloc2;
	logic [`RS_SIZE-1:0]      issue_clear;
	logic [`RS_SIZE-1:0]      flush_clear;
	rs_idx_t [`NUM_FU-1:0]    issue_sel;
	logic [`RS_SIZE-1:0]      busy;
	logic [`RS_SIZE-1:0]      ready;
	fu_class_t [`RS_SIZE-1:0] ent_class;
	rob_idx_t [`RS_SIZE-1:0]  ent_rob_idx;
	issue_t [`RS_SIZE-1:0]    ent_payload;

	rs_operand_bypass u_bypass (
		.inst1 (inst1),
		.inst2 (inst2),
		.cdb1  (cdb1),
		.cdb2  (cdb2),
		.fwd1  (fwd1),
		.fwd2  (fwd2)
	);

	rs_entry_array u_entries (
		.clk         (clk),
		.rst         (rst),
		.fwd1        (fwd1),
		.fwd2        (fwd2),
		.alloc1      (alloc1),
		.alloc2      (alloc2),
		.cdb1        (cdb1),
		.cdb2        (cdb2),
		.issue_clear (issue_clear),
		.flush_clear (flush_clear),
		.busy        (busy),
		.ready       (ready),
		.ent_class   (ent_class),
		.ent_rob_idx (ent_rob_idx),
		.ent_payload (ent_payload)
	);

	rs_control u_control (
		.clk             (clk),
		.rst             (rst),
		.inst1_load      (inst1.load),
		.inst2_load      (inst2.load),
		.busy            (busy),
		.ready           (ready),
		.ent_class       (ent_class),
		.ent_rob_idx     (ent_rob_idx),
		.fu_available    (fu_available),
		.branch_taken_t1 (branch_taken_t1),
		.branch_taken_t2 (branch_taken_t2),
		.alloc1          (alloc1),
		.alloc2          (alloc2),
		.issue_clear     (issue_clear),
		.issue_sel       (issue_sel),
		.fu_valid        (fu_valid),
		.flush_clear     (flush_clear),
		.rs_full         (rs_full)
	);

	rs_issue_mux u_issue_mux (
		.ent_payload (ent_payload),
		.issue_sel   (issue_sel),
		.fu_valid    (fu_valid),
		.fu_issue    (fu_issue)
	);

endmodule

/* dv/rs_tb.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_tb;
	import rs_pkg::*;

	localparam int W = `NUM_FU * $bits(issue_t);

	logic                     clk = 1'b0;
	logic                     rst;
	dispatch_t                inst1;
	dispatch_t                inst2;
	cdb_t                     cdb1;
	cdb_t                     cdb2;
	logic [`NUM_FU-1:0]       fu_available;
	logic                     branch_taken_t1;
	logic                     branch_taken_t2;
	issue_t [`NUM_FU-1:0]     fu_issue;
	logic [`NUM_FU-1:0]       fu_valid;
	logic                     rs_full;

	logic [`RS_SIZE-1:0]      m_busy;     // model occupancy
	dispatch_t [`RS_SIZE-1:0] m_ent;
	logic [`RS_SIZE-1:0]      exp_taken;  // model entries leaving by issue this cycle
	logic [`NUM_FU-1:0]       exp_valid;
	issue_t [`NUM_FU-1:0]     exp_issue;

	always #4 clk = ~clk;

	rs_top dut (.*);

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("TEST FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic value_error(input string name, input logic [W-1:0] got,
			input logic [W-1:0] exp);
		$display("ERROR %0t %s dut=%0h exp=%0h", $time, name, got, exp);
		abort_run({name, " mismatch"});
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// a waiting operand takes the first bus whose tag matches
	function automatic operand_t snoop(input operand_t op);
		if (op.valid)
			return op;
		if (cdb1.valid && cdb1.tag == tag_t'(op.value))
			return '{value: cdb1.value, valid: 1'b1};
		if (cdb2.valid && cdb2.tag == tag_t'(op.value))
			return '{value: cdb2.value, valid: 1'b1};
		return op;
	endfunction

	function automatic dispatch_t arrive(input dispatch_t d);
		dispatch_t r;
		r = d;
		r.opa = snoop(d.opa);
		r.opb = snoop(d.opb);
		return r;
	endfunction

	// n-th ready entry of a class goes to the n-th available port of that class
	always_comb begin
		int slot [2];
		int nslot;
		int used;
		slot[0] = 0;
		slot[1] = 0;
		exp_valid = '0;
		exp_issue = '0;
		exp_taken = '0;
		for (int c = 0; c < `NUM_FU / `FU_PER_CLASS; c++) begin
			nslot = 0;
			used = 0;
			for (int p = c * `FU_PER_CLASS; p < (c + 1) * `FU_PER_CLASS; p++) begin
				if (fu_available[p]) begin
					slot[nslot] = p;
					nslot++;
				end
			end
			for (int i = 0; i < `RS_SIZE; i++) begin
				if (used < nslot && m_busy[i] && m_ent[i].opa.valid && m_ent[i].opb.valid
						&& m_ent[i].fu_class == fu_class_t'(c)) begin
					exp_valid[slot[used]] = 1'b1;
					exp_issue[slot[used]] = '{opa: m_ent[i].opa.value, opb: m_ent[i].opb.value,
						dest: m_ent[i].dest, rob_idx: m_ent[i].rob_idx,
						alu_func: m_ent[i].alu_func};
					exp_taken[i] = 1'b1;
					used++;
				end
			end
		end
	end

	always @(posedge clk) begin
		int first;
		int second;
		logic [`RS_SIZE-1:0] nxt;
		first = -1;
		second = -1;
		for (int i = 0; i < `RS_SIZE; i++) begin
			nxt[i] = m_busy[i] && !exp_taken[i] && !(m_ent[i].rob_idx[$clog2(`ROB_SIZE)] ?
				branch_taken_t2 : branch_taken_t1);
			if (!m_busy[i] && first < 0)
				first = i;
			else if (!m_busy[i] && second < 0)
				second = i;
			m_ent[i].opa <= snoop(m_ent[i].opa);
			m_ent[i].opb <= snoop(m_ent[i].opb);
		end
		if (inst1.load && first >= 0) begin
			m_ent[first] <= arrive(inst1);
			nxt[first] = 1'b1;
		end
		if (inst1.load && inst2.load && second >= 0) begin  // inst2 never loads alone
			m_ent[second] <= arrive(inst2);
			nxt[second] = 1'b1;
		end
		m_busy <= rst ? '0 : nxt;
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_after_reset: assert property (@(posedge clk) $fell(rst) |-> (fu_valid == '0 && !rs_full))
		else abort_run("fu_valid or rs_full active right after reset");
	a_fu_valid: assert property (@(posedge clk) disable iff (rst) fu_valid == exp_valid)
		else value_error("fu_valid", $sampled(fu_valid), $sampled(exp_valid));
	a_fu_issue: assert property (@(posedge clk) disable iff (rst) fu_issue == exp_issue)
		else value_error("fu_issue", $sampled(fu_issue), $sampled(exp_issue));
	a_rs_full: assert property (@(posedge clk) disable iff (rst) rs_full == (&m_busy))
		else value_error("rs_full", $sampled(rs_full), $sampled(&m_busy));

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// negative tag means the operand arrives valid and thread bit 0 is thread 1
	function automatic dispatch_t make_inst(input fu_class_t cls, input logic thread,
			input int ta, input int tb);
		dispatch_t d;
		d.load = 1'b1;
		d.dest = tag_t'($urandom);
		d.opa.valid = (ta < 0);
		d.opa.value = (ta < 0) ? {$urandom, $urandom} : word_t'(ta);
		d.opb.valid = (tb < 0);
		d.opb.value = (tb < 0) ? {$urandom, $urandom} : word_t'(tb);
		d.rob_idx = rob_idx_t'($urandom);
		d.rob_idx[$clog2(`ROB_SIZE)] = thread;
		d.alu_func = alu_func_t'($urandom_range(17, 1));
		d.fu_class = cls;
		return d;
	endfunction

	function automatic cdb_t make_cdb(input int tag);
		cdb_t c;
		c.value = {$urandom, $urandom};
		c.tag = tag_t'(tag);
		c.valid = 1'b1;
		return c;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
		inst1.load = 1'b0;  // strobes last one cycle
		inst2.load = 1'b0;
		cdb1.valid = 1'b0;
		cdb2.valid = 1'b0;
		branch_taken_t1 = 1'b0;
		branch_taken_t2 = 1'b0;
	endtask

	task automatic wait_issue(input logic [`NUM_FU-1:0] ports);
		int n;
		n = 0;
		#1;
		while ((fu_valid & ports) != ports) begin
			if (n == 20)
				abort_run("expected issue never appeared");
			next_cycle();
			#1;
			n++;
		end
	endtask

	task automatic wait_full();
		int n;
		n = 0;
		#1;
		while (!rs_full) begin
			if (n == 20)
				abort_run("station never reported full");
			next_cycle();
			#1;
			n++;
		end
	endtask

	initial begin
		void'($urandom(43187));
		rst = 1'b1;
		inst1 = '0;
		inst2 = '0;
		cdb1 = '0;
		cdb2 = '0;
		fu_available = '1;
		branch_taken_t1 = 1'b0;
		branch_taken_t2 = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		next_cycle();

		inst1 = make_inst(FU_ADDER, 1'b0, -1, -1);
		inst2 = make_inst(FU_MULT, 1'b1, -1, -1);
		next_cycle();
		wait_issue(6'b000101);
		next_cycle();

		// bypass at dispatch and a later wakeup with both buses carrying the same tag
		inst1 = make_inst(FU_MEMORY, 1'b0, 5, -1);
		inst2 = make_inst(FU_ADDER, 1'b1, -1, 9);
		cdb1 = make_cdb(5);
		cdb2 = make_cdb(5);
		next_cycle();
		cdb1 = make_cdb(9);
		cdb2 = make_cdb(9);
		wait_issue(6'b010000);
		next_cycle();
		wait_issue(6'b000100);
		next_cycle();

		// multipliers held off and then issued on both ports at once
		fu_available = 6'b111100;
		inst1 = make_inst(FU_MULT, 1'b0, -1, -1);
		inst2 = make_inst(FU_MULT, 1'b1, -1, -1);
		repeat (4) next_cycle();
		fu_available = '1;
		wait_issue(6'b000011);
		next_cycle();
		fu_available = 6'b111110;
		inst1 = make_inst(FU_MULT, 1'b1, -1, -1);
		next_cycle();
		wait_issue(6'b000010);
		next_cycle();

		// thread 1 flush while nothing can issue
		fu_available = '0;
		inst1 = make_inst(FU_ADDER, 1'b0, -1, -1);
		inst2 = make_inst(FU_MEMORY, 1'b1, -1, -1);
		next_cycle();
		inst1 = make_inst(FU_MULT, 1'b0, -1, 12);
		inst2 = make_inst(FU_ADDER, 1'b1, -1, -1);
		next_cycle();
		branch_taken_t1 = 1'b1;
		next_cycle();
		fu_available = '1;
		cdb1 = make_cdb(12);  // flushed mult must stay gone
		wait_issue(6'b010100);
		repeat (3) next_cycle();

		// fill all entries so that extra loads are dropped
		fu_available = '0;
		repeat (3) begin
			inst1 = make_inst(FU_ADDER, 1'b0, -1, -1);
			inst2 = make_inst(FU_MEMORY, 1'b1, -1, -1);
			next_cycle();
		end
		inst2 = make_inst(FU_MULT, 1'b1, -1, -1);  // dropped without an inst1 load
		next_cycle();
		inst1 = make_inst(FU_ADDER, 1'b0, -1, -1);
		next_cycle();
		inst1 = make_inst(FU_MEMORY, 1'b1, -1, -1);
		inst2 = make_inst(FU_MULT, 1'b0, -1, -1);  // only one entry left for the pair
		next_cycle();
		wait_full();
		inst1 = make_inst(FU_MULT, 1'b0, -1, -1);
		inst2 = make_inst(FU_MULT, 1'b1, -1, -1);
		repeat (3) next_cycle();
		fu_available = '1;
		repeat (8) next_cycle();

		$display("TEST PASS");
		$finish;
	end

endmodule

/* project.f */
+incdir+design
design/rs_pkg.sv
design/rs_operand_bypass.sv
design/rs_entry_array.sv
design/rs_control.sv
design/rs_issue_mux.sv
design/rs_top.sv
dv/rs_tb.sv
